//--- hw/ion_defs.svh
// Widths, table depth, report interval and fixed packet field values, included by the RTL
`ifndef ION_DEFS_SVH
`define ION_DEFS_SVH

// ------------------------------
// Sizes
// ------------------------------

`define ION_PACKET_W         110     // One report packet
`define ION_TIMER_W          16      // Interval counter
`define ION_INTERVAL_DEFAULT 16'hAAAA // Cycles spent waiting between reports

`define ION_TABLE_DEPTH      32      // Stored samples
`define ION_INDEX_W          5       // Enough to address every stored sample

// ------------------------------
// Constant packet fields
// ------------------------------

// Framing bytes at the low end of the packet
`define ION_START_CODE       7'd77
`define ION_SYNC_CODE        8'd255

// Sensor identity
`define ION_ID_HI            8'd239
`define ION_ID_LO            8'd17
`define ION_CHANNEL          6'd1
`define ION_SERIAL           24'd4272433

`endif

//--- hw/ion_packet_pkg.sv
// Packet word type shared by the sample table, the top level and the testbench
`include "ion_defs.svh"

package ion_packet_pkg;

	// ------------------------------
	// Report packet
	// ------------------------------

	// One word seen either as a flat vector or as its fields, MSB first
	typedef union packed
	{
		logic [`ION_PACKET_W-1:0] raw; // Whole word as sent on data_out
		struct packed
		{
			logic [23:0] serial;       // Bits 109..86
			logic [5:0]  channel;      // Bits 85..80
			logic [15:0] ion_count;    // Bits 79..64
			logic [7:0]  id_lo;        // Bits 63..56
			logic [7:0]  id_hi;        // Bits 55..48
			logic [15:0] sample_count; // Bits 47..32
			logic [7:0]  level_b;      // Bits 31..24
			logic [7:0]  level_a;      // Bits 23..16
			logic [7:0]  sync_code;    // Bits 15..8
			logic        flag;         // Bit 7
			logic [6:0]  start_code;   // Bits 6..0
		} fields;
	} ion_packet_t;

endpackage

//--- hw/ion_ctrl_pkg.sv
// State encoding of the report sequencer, shared with the testbench for debug display
package ion_ctrl_pkg;

	typedef enum logic [1:0]
	{
		START       = 2'b00, // One cycle after reset
		IDLE        = 2'b01, // Waiting for the interval to run out
		READ_PACKET = 2'b10, // Timer cleared for the next wait
		SEND_PACKET = 2'b11  // Packet on data_out, ready high
	} ion_state_t;

endpackage

//--- hw/ion_report_timer.sv
// Report interval counter, counts enabled cycles and flags the end of each wait
`timescale 1ns/1ps
`include "ion_defs.svh"

module ion_report_timer #(
	parameter logic [`ION_TIMER_W-1:0] interval_count = `ION_INTERVAL_DEFAULT
) (
	input  logic clock,
	input  logic resetn,
	input  logic count_enable,
	input  logic clear,
	output logic interval_done
);

	logic [`ION_TIMER_W-1:0] count;

	// ------------------------------
	// Counter
	// ------------------------------

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (clear)
			count <= '0; // Restart for the next wait
		else if (count_enable && !interval_done)
			count <= count + 1'b1; // Holds at terminal count
	end

	assign interval_done = (count == interval_count);

	// ------------------------------
	// Checks
	// ------------------------------

	// Sequencer must leave IDLE at terminal count so the wait never overruns
	wait_ends_at_terminal: assert property (
		@(posedge clock) disable iff (!resetn)
		count_enable && interval_done |=> !count_enable
	);

endmodule

//--- hw/ion_report_fsm.sv
// Report sequencer, walks START, IDLE, READ_PACKET, SEND_PACKET and owns the sample index
`timescale 1ns/1ps
`include "ion_defs.svh"

module ion_report_fsm
	import ion_ctrl_pkg::*;
(
	input  logic                    clock,
	input  logic                    resetn,
	input  logic                    interval_done,
	output logic                    count_enable,
	output logic                    clear,
	output logic [`ION_INDEX_W-1:0] sample_index,
	output logic                    send,
	output logic                    ready
);

	localparam logic [`ION_INDEX_W-1:0] last_index = `ION_INDEX_W'(`ION_TABLE_DEPTH - 1);

	ion_state_t state;
	ion_state_t next_state;

	// ------------------------------
	// State register
	// ------------------------------

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= START;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			START:
				next_state = IDLE;
			IDLE:
				if (interval_done)
					next_state = READ_PACKET;
			READ_PACKET:
				next_state = SEND_PACKET;
			SEND_PACKET:
				next_state = IDLE;
			default:
				next_state = START;
		endcase
	end

	// Next entry is selected as the current packet goes out
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			sample_index <= '0;
		else if (state == SEND_PACKET)
			sample_index <= (sample_index == last_index) ? '0 : sample_index + 1'b1;
	end

	// ------------------------------
	// Outputs
	// ------------------------------

	assign count_enable = (state == IDLE);
	assign clear        = (state == READ_PACKET);
	assign send         = (state == SEND_PACKET);
	assign ready        = (state == SEND_PACKET); // Strobe, no handshake

	ready_single_cycle: assert property (
		@(posedge clock) disable iff (!resetn)
		ready |=> !ready
	);

	ready_after_read: assert property (
		@(posedge clock) disable iff (!resetn)
		ready |-> $past(state == READ_PACKET)
	);

endmodule

//--- hw/ion_sample_table.sv
// Stored sample table, merges one recorded entry with the fixed fields into a packet
`timescale 1ns/1ps
`include "ion_defs.svh"

module ion_sample_table
	import ion_packet_pkg::*;
(
	input  logic [`ION_INDEX_W-1:0] sample_index,
	input  logic                    send,
	output ion_packet_t             data_out
);

	localparam int entry_w = 1 + 8 + 8 + 16 + 16; // flag, level_a, level_b, sample_count, ion_count

	logic [entry_w-1:0] entry;
	logic               flag;
	logic [7:0]         level_a;
	logic [7:0]         level_b;
	logic [15:0]        sample_count;
	logic [15:0]        ion_count;
	ion_packet_t        packet;

	// ------------------------------
	// Recorded samples
	// ------------------------------

	always_comb
	begin
		case (sample_index)
			5'd0:    entry = {1'b0, 8'd177, 8'd100, 16'd881,  16'd56110};
			5'd1:    entry = {1'b1, 8'd176, 8'd100, 16'd925,  16'd3791};
			5'd2:    entry = {1'b0, 8'd177, 8'd100, 16'd962,  16'd63275};
			5'd3:    entry = {1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			5'd4:    entry = {1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
			5'd5:    entry = {1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
			5'd6:    entry = {1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
			5'd7:    entry = {1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
			5'd8:    entry = {1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
			5'd9:    entry = {1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
			5'd10:   entry = {1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
			5'd11:   entry = {1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
			5'd12:   entry = {1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
			5'd13:   entry = {1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
			5'd14:   entry = {1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
			5'd15:   entry = {1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
			5'd16:   entry = {1'b1, 8'd177, 8'd100, 16'd1556, 16'd145};
			5'd17:   entry = {1'b1, 8'd178, 8'd100, 16'd1598, 16'd21191};
			5'd18:   entry = {1'b0, 8'd177, 8'd100, 16'd1635, 16'd610};
			5'd19:   entry = {1'b1, 8'd177, 8'd100, 16'd1679, 16'd4089};
			5'd20:   entry = {1'b0, 8'd178, 8'd100, 16'd1729, 16'd20685};
			5'd21:   entry = {1'b1, 8'd177, 8'd100, 16'd1766, 16'd10459};
			5'd22:   entry = {1'b1, 8'd178, 8'd100, 16'd1815, 16'd57766};
			5'd23:   entry = {1'b0, 8'd177, 8'd100, 16'd1857, 16'd48236};
			5'd24:   entry = {1'b1, 8'd177, 8'd100, 16'd1903, 16'd36453};
			5'd25:   entry = {1'b0, 8'd183, 8'd100, 16'd1945, 16'd22977};
			5'd26:   entry = {1'b0, 8'd177, 8'd100, 16'd1987, 16'd13045};
			5'd27:   entry = {1'b0, 8'd177, 8'd100, 16'd2033, 16'd40993};
			5'd28:   entry = {1'b1, 8'd177, 8'd100, 16'd2075, 16'd45310};
			5'd29:   entry = {1'b1, 8'd177, 8'd100, 16'd2108, 16'd62988};
			5'd30:   entry = {1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032};
			5'd31:   entry = {1'b1, 8'd178, 8'd100, 16'd2199, 16'd22312};
			default: entry = '0;
		endcase
	end

	assign {flag, level_a, level_b, sample_count, ion_count} = entry;

	// ------------------------------
	// Packet assembly
	// ------------------------------

	always_comb
	begin
		packet.fields.serial       = `ION_SERIAL;
		packet.fields.channel      = `ION_CHANNEL;
		packet.fields.ion_count    = ion_count;
		packet.fields.id_lo        = `ION_ID_LO;
		packet.fields.id_hi        = `ION_ID_HI;
		packet.fields.sample_count = sample_count;
		packet.fields.level_b      = level_b;
		packet.fields.level_a      = level_a;
		packet.fields.sync_code    = `ION_SYNC_CODE;
		packet.fields.flag         = flag;
		packet.fields.start_code   = `ION_START_CODE;
	end

	assign data_out.raw = send ? packet.raw : '0; // Line idles at zero between reports

endmodule

//--- hw/ion_sensor_sim.sv
// Ion sensor model top level, sends one stored sample packet per report interval
`timescale 1ns/1ps
`include "ion_defs.svh"

module ion_sensor_sim
	import ion_packet_pkg::*;
#(
	parameter logic [`ION_TIMER_W-1:0] interval_count = `ION_INTERVAL_DEFAULT
) (
	input  logic        clock,
	input  logic        resetn,
	output logic        ready,
	output ion_packet_t data_out
);

	logic                    count_enable;
	logic                    clear;
	logic                    interval_done;
	logic [`ION_INDEX_W-1:0] sample_index;
	logic                    send;

	// ------------------------------
	// Blocks
	// ------------------------------

	ion_report_timer #(
		.interval_count(interval_count)
	) u_timer (
		.clock        (clock),
		.resetn       (resetn),
		.count_enable (count_enable),
		.clear        (clear),
		.interval_done(interval_done)
	);

	ion_report_fsm u_fsm (
		.clock        (clock),
		.resetn       (resetn),
		.interval_done(interval_done),
		.count_enable (count_enable),
		.clear        (clear),
		.sample_index (sample_index),
		.send         (send),
		.ready        (ready)
	);

	ion_sample_table u_table (
		.sample_index(sample_index),
		.send        (send),
		.data_out    (data_out)
	);

endmodule

//--- verif/ion_sensor_sim_tests.svh
// Directed tests of the ion sensor model, included into the testbench module body
`ifndef ION_SENSOR_SIM_TESTS_SVH
`define ION_SENSOR_SIM_TESTS_SVH

	// ------------------------------
	// Sequence helpers
	// ------------------------------

	// Entered at the drive point, holds reset for two cycles
	task automatic hold_reset();
		resetn = 1'b0;
		repeat (2)
		begin
			@(negedge clock);
			if (ready !== 1'b0)
				report_mismatch("ready", ready, 1'b0);
			if (data_out.raw !== '0)
				report_mismatch("data_out", data_out.raw, '0);
			@(posedge clock);
		end
		#1 resetn = 1'b1;
		@(negedge clock); // First cycle out of reset
		if (ready !== 1'b0)
			report_mismatch("ready", ready, 1'b0);
		if (data_out.raw !== '0)
			report_mismatch("data_out", data_out.raw, '0);
	endtask

	// Counts rising edges until the capture process has seen a new packet
	task automatic wait_packet(output ion_packet_t pkt, output int cycles, output bit ok);
		int         start_count;
		ion_state_t seen_state;
		start_count = packets.size();
		cycles      = 0;
		ok          = 1'b0;
		pkt         = '0;
		while (packets.size() == start_count && cycles < ready_timeout)
		begin
			@(posedge clock);
			cycles++;
		end
		if (packets.size() > start_count)
		begin
			ok  = 1'b1;
			pkt = packets[start_count];
		end
		else
		begin
			seen_state = DUT.u_fsm.state;
			report_failure($sformatf("no ready pulse within %0d cycles, sequencer in %s",
				ready_timeout, seen_state.name()));
		end
	endtask

	task automatic collect_packets(input int total);
		ion_packet_t pkt;
		int          cycles;
		bit          ok;
		ok = 1'b1;
		while (ok && packets.size() < total)
		begin
			wait_packet(pkt, cycles, ok);
			if (ok && cycles != period)
				report_mismatch("ready period", cycles, period);
		end
	endtask

	// ------------------------------
	// Tests
	// ------------------------------

	task automatic startup_from_reset();
		ion_packet_t pkt;
		int          cycles;
		bit          ok;
		hold_reset();
		wait_packet(pkt, cycles, ok);
		if (ok && cycles != first_latency)
			report_mismatch("first ready latency", cycles, first_latency);
	endtask

	task automatic pulse_shape_and_period();
		ion_packet_t pkt;
		int          cycles;
		bit          ok;
		int          n;
		for (n = 0; n < 4; n++)
		begin
			wait_packet(pkt, cycles, ok);
			if (!ok)
				return;
			if (cycles != period)
				report_mismatch("ready period", cycles, period);
			@(negedge clock);
			if (ready !== 1'b0)
				report_failure("ready still high one cycle after a pulse");
		end
	endtask

	task automatic sample_ordering();
		int i;
		collect_packets(table_depth);
		if (packets.size() < table_depth)
		begin
			report_failure("fewer than 32 packets arrived");
			return;
		end
		for (i = 1; i < table_depth; i++)
		begin
			if (packets[i].fields.sample_count <= packets[i-1].fields.sample_count)
				report_failure($sformatf("sample_count of packet %0d (%0d) not above packet %0d (%0d)",
					i + 1, packets[i].fields.sample_count, i, packets[i-1].fields.sample_count));
		end
		for (i = 0; i < table_depth; i++)
		begin
			if (packets[i].fields.level_b != 8'd100 && packets[i].fields.level_b != 8'd101)
				report_failure($sformatf("level_b of packet %0d is %0d, outside 100..101",
					i + 1, packets[i].fields.level_b));
		end
	endtask

	task automatic fixed_fields();
		int i;
		for (i = 0; i < packets.size(); i++)
		begin
			if (packets[i].fields.start_code !== start_code_exp)
				report_mismatch($sformatf("packet %0d start_code", i + 1),
					packets[i].fields.start_code, start_code_exp);
			if (packets[i].fields.sync_code !== sync_code_exp)
				report_mismatch($sformatf("packet %0d sync_code", i + 1),
					packets[i].fields.sync_code, sync_code_exp);
			if (packets[i].fields.id_hi !== id_hi_exp)
				report_mismatch($sformatf("packet %0d id_hi", i + 1), packets[i].fields.id_hi, id_hi_exp);
			if (packets[i].fields.id_lo !== id_lo_exp)
				report_mismatch($sformatf("packet %0d id_lo", i + 1), packets[i].fields.id_lo, id_lo_exp);
			if (packets[i].fields.channel !== channel_exp)
				report_mismatch($sformatf("packet %0d channel", i + 1),
					packets[i].fields.channel, channel_exp);
			if (packets[i].fields.serial !== serial_exp)
				report_mismatch($sformatf("packet %0d serial", i + 1), packets[i].fields.serial, serial_exp);
		end
	endtask

	task automatic index_wrap();
		collect_packets(table_depth + 2);
		if (packets.size() < table_depth + 2)
		begin
			report_failure("index wrap not reached, packets missing");
			return;
		end
		if (packets[32].raw !== packets[0].raw)
			report_mismatch("packet 33", packets[32].raw, packets[0].raw);
		if (packets[33].raw !== packets[1].raw)
			report_mismatch("packet 34", packets[33].raw, packets[1].raw);
	endtask

	// Starts on the edge that captured the last packet, cuts the next pulse with reset
	task automatic reset_during_pulse();
		ion_packet_t pkt;
		int          cycles;
		bit          ok;
		if (packets.size() == 0)
		begin
			report_failure("no reference packet for the reset test");
			return;
		end
		repeat (period - 1) @(posedge clock);
		#1;
		if (ready !== 1'b1)
			report_failure("ready was not high where the next pulse was due");
		hold_reset();
		wait_packet(pkt, cycles, ok);
		if (!ok)
			return;
		if (cycles != first_latency)
			report_mismatch("ready latency after reset", cycles, first_latency);
		if (pkt.raw !== packets[0].raw)
			report_mismatch("packet after reset", pkt.raw, packets[0].raw);
	endtask

`endif

//--- verif/ion_sensor_sim_tb.sv
// Testbench for the ion sensor model, runs the directed tests and prints the closing result
`timescale 1ns/1ps
`include "ion_defs.svh"

module ion_sensor_sim_tb
	import ion_packet_pkg::*;
	import ion_ctrl_pkg::*;
();

	localparam int interval      = 12;
	localparam int first_latency = interval + 4; // START, IDLE run, READ_PACKET, SEND_PACKET
	localparam int period        = interval + 3;
	localparam int ready_timeout = 100;
	localparam int table_depth   = 32;

	// Fixed packet fields of the sensor
	localparam logic [6:0]  start_code_exp = 7'd77;
	localparam logic [7:0]  sync_code_exp  = 8'd255;
	localparam logic [7:0]  id_hi_exp      = 8'd239;
	localparam logic [7:0]  id_lo_exp      = 8'd17;
	localparam logic [5:0]  channel_exp    = 6'd1;
	localparam logic [23:0] serial_exp     = 24'd4272433;

	logic        clock;
	logic        resetn;
	logic        ready;
	ion_packet_t data_out;

	ion_packet_t packets[$]; // Every packet seen on a ready cycle
	logic        ready_prev;
	int          value_errors;
	int          other_errors;

	ion_sensor_sim #(
		.interval_count(16'(interval))
	) DUT (
		.clock   (clock),
		.resetn  (resetn),
		.ready   (ready),
		.data_out(data_out)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ------------------------------
	// Error reporting
	// ------------------------------

	task automatic report_mismatch(input string name, input logic [`ION_PACKET_W-1:0] got,
		input logic [`ION_PACKET_W-1:0] expected);
		value_errors++;
		$display("** Error at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, expected);
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ------------------------------
	// Packet capture
	// ------------------------------

	// Outputs settle between edges, so everything is sampled on the falling edge
	always @(negedge clock)
	begin
		if (!ready && data_out.raw !== '0)
			report_mismatch("data_out", data_out.raw, '0);
		if (ready && ready_prev)
			report_failure("ready stayed high for more than one cycle");
		if (ready === 1'b1)
			packets.push_back(data_out);
		ready_prev = resetn && ready;
	end

	`include "ion_sensor_sim_tests.svh"

	initial
	begin
		resetn       = 1'b0;
		ready_prev   = 1'b0;
		value_errors = 0;
		other_errors = 0;

		startup_from_reset();
		pulse_shape_and_period();
		sample_ordering();
		fixed_fields();
		index_wrap();
		reset_during_pulse();

		$display("Captured %0d packets: %0d value errors, %0d other errors",
			packets.size(), value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- ion_sensor_sim.f
+incdir+hw
+incdir+verif
hw/ion_packet_pkg.sv
hw/ion_ctrl_pkg.sv
hw/ion_report_timer.sv
hw/ion_report_fsm.sv
hw/ion_sample_table.sv
hw/ion_sensor_sim.sv
verif/ion_sensor_sim_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ion_sensor_sim_tb \
		-f ion_sensor_sim.f -Mdir obj_dir -o ion_sensor_sim_tb
	@out=$$(./obj_dir/ion_sensor_sim_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
